// ==== source/spi_settings.svh ====
// SPI master settings: frame width, FIFO depth and serial clock rate
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// Bits per SPI frame, sent MSB first
`define SPI_WORD_WIDTH 8

// Entries in each of the transmit and receive FIFOs
// Must be a power of two so the pointers wrap on their own
`define SPI_FIFO_DEPTH 4

// System clocks per serial clock half period, at least 1
// One full frame takes 16 times this many clocks
`define SPI_HALF_PERIOD 2

`endif

// ==== source/spi_pkg.sv ====
// SPI master types: clock mode, engine states and the pin bundle
package spi_pkg;

    // Serial clock polarity and phase
    typedef struct packed {
        logic cpol;
        logic cpha;
    } spi_mode_t;

    // Shift engine states
    typedef enum logic [1:0] {
        spi_idle,
        spi_shift,
        spi_finish
    } spi_state_e;

    // Pins driven towards the slave
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic cs_n;
    } spi_pins_t;

endpackage

// ==== source/spi_byte_fifo.sv ====
// Byte FIFO with valid/ready handshakes on the write and the read side
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_byte_fifo (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [`SPI_WORD_WIDTH-1:0] in_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [`SPI_WORD_WIDTH-1:0] out_data
);

    localparam int DEPTH = `SPI_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`SPI_WORD_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;
    logic                       push;
    logic                       pop;

    // Full and empty come straight from the registered count
    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // Head of the queue is always on the output
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // Pointer distance always agrees with the count
    a_ptrs_track_count: assert property (
        @(posedge clock) disable iff (reset)
        (wr_ptr - rd_ptr) == count[PTR_W-1:0]
    ) else $error("spi_byte_fifo pointers out of step with the count");

    // Whatever sits at the head was written before it is offered
    a_head_written: assert property (
        @(posedge clock) disable iff (reset)
        out_valid |-> !$isunknown(out_data)
    ) else $error("spi_byte_fifo offered an entry that was never written");

endmodule

// ==== source/spi_clock_phase.sv ====
// Serial clock generator with leading and trailing edge strobes
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_clock_phase (
    input  logic              clock,
    input  logic              reset,
    input  logic              run,
    input  spi_pkg::spi_mode_t mode,
    output logic              sclk,
    output logic              lead_edge,
    output logic              trail_edge
);

    localparam int HALF  = `SPI_HALF_PERIOD;
    localparam int CNT_W = $clog2(HALF + 1);

    logic [CNT_W-1:0] count;
    logic             count_end;
    // Low while sclk sits at its idle level
    logic             phase;

    assign count_end = (count == CNT_W'(HALF - 1));

    // Strobes mark the last cycle before the level flips
    assign lead_edge  = run && count_end && !phase;
    assign trail_edge = run && count_end && phase;

    // Idle level is cpol, active level is its inverse
    assign sclk = run ? (mode.cpol ^ phase) : mode.cpol;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
            phase <= 1'b0;
        end else if (!run) begin
            count <= '0;
            phase <= 1'b0;
        end else if (count_end) begin
            count <= '0;
            phase <= ~phase;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Trailing edge follows each leading edge after one half period
    a_lead_then_trail: assert property (
        @(posedge clock) disable iff (reset)
        lead_edge |-> ##HALF trail_edge
    ) else $error("trailing edge did not follow the leading edge in time");

    // The level really moves after each strobe
    a_lead_moves_clock: assert property (
        @(posedge clock) disable iff (reset)
        lead_edge |=> (sclk != mode.cpol)
    ) else $error("sclk did not leave idle after a leading edge");

    a_trail_moves_clock: assert property (
        @(posedge clock) disable iff (reset)
        trail_edge |=> (sclk == mode.cpol)
    ) else $error("sclk did not return to idle after a trailing edge");

endmodule

// ==== source/spi_shift_engine.sv ====
// SPI frame engine: shift registers, bit counter and chip select control
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_shift_engine (
    input  logic                       clock,
    input  logic                       reset,
    input  spi_pkg::spi_mode_t         mode_in,
    input  logic                       tx_valid,
    output logic                       tx_pop,
    input  logic [`SPI_WORD_WIDTH-1:0] tx_byte,
    input  logic                       rx_space,
    output logic                       rx_push,
    output logic [`SPI_WORD_WIDTH-1:0] rx_byte,
    output logic                       run,
    output spi_pkg::spi_mode_t         mode,
    input  logic                       sclk,
    input  logic                       lead_edge,
    input  logic                       trail_edge,
    input  logic                       miso,
    output spi_pkg::spi_pins_t         pins,
    output spi_pkg::spi_state_e        state
);

    localparam int WORD  = `SPI_WORD_WIDTH;
    localparam int BIT_W = $clog2(WORD + 1);
    localparam int FRAME = 16 * `SPI_HALF_PERIOD;

    spi_pkg::spi_mode_t mode_reg;
    logic [WORD-1:0]    tx_reg;
    logic [WORD-1:0]    rx_reg;
    logic [BIT_W-1:0]   bit_count;
    logic               cs_n;
    logic               sample_edge;
    logic               shift_edge;
    logic               last_edge;

    // Mode 0/2 samples on the leading edge, mode 1/3 on the trailing edge
    assign sample_edge = mode_reg.cpha ? trail_edge : lead_edge;

    // With cpha set the first leading edge only launches bit 7
    assign shift_edge = mode_reg.cpha ? (lead_edge && (bit_count != BIT_W'(WORD)))
                                      : trail_edge;

    // Closing edge of the frame is the trailing edge after the eighth sample
    assign last_edge = trail_edge &&
                       ((bit_count == '0) || (mode_reg.cpha && (bit_count == BIT_W'(1))));

    // Idle clock level follows the live cpol, frozen once a frame starts
    assign mode = (state == spi_pkg::spi_idle) ? mode_in : mode_reg;

    assign run     = (state == spi_pkg::spi_shift);
    assign rx_push = (state == spi_pkg::spi_finish);
    assign rx_byte = rx_reg;

    assign pins.sclk = sclk;
    assign pins.mosi = cs_n ? 1'b0 : tx_reg[WORD-1];
    assign pins.cs_n = cs_n;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= spi_pkg::spi_idle;
            tx_pop    <= 1'b0;
            cs_n      <= 1'b1;
            bit_count <= '0;
            mode_reg  <= '0;
        end else begin
            case (state)
                spi_pkg::spi_idle: begin
                    if (tx_pop) begin
                        // Head byte is still on tx_byte in the pop cycle
                        tx_pop    <= 1'b0;
                        mode_reg  <= mode_in;
                        cs_n      <= 1'b0;
                        bit_count <= BIT_W'(WORD);
                        state     <= spi_pkg::spi_shift;
                    end else if (tx_valid && rx_space) begin
                        tx_pop <= 1'b1;
                    end
                end
                spi_pkg::spi_shift: begin
                    if (sample_edge) begin
                        bit_count <= bit_count - 1'b1;
                    end
                    if (last_edge) begin
                        cs_n  <= 1'b1;
                        state <= spi_pkg::spi_finish;
                    end
                end
                spi_pkg::spi_finish: begin
                    state <= spi_pkg::spi_idle;
                end
                default: begin
                    state <= spi_pkg::spi_idle;
                end
            endcase
        end
    end

    // Data path shifts MSB first in both directions
    always_ff @(posedge clock) begin
        if ((state == spi_pkg::spi_idle) && tx_pop) begin
            tx_reg <= tx_byte;
        end else if (shift_edge) begin
            tx_reg <= {tx_reg[WORD-2:0], 1'b0};
        end
        if (sample_edge) begin
            rx_reg <= {rx_reg[WORD-2:0], miso};
        end
    end

    // cs_n stays low for exactly sixteen half periods per frame
    a_cs_frame_length: assert property (
        @(posedge clock) disable iff (reset)
        $fell(cs_n) |-> ##FRAME $rose(cs_n)
    ) else $error("cs_n low period has the wrong length");

    // Space was checked at frame start and must still be there at the push
    a_push_has_space: assert property (
        @(posedge clock) disable iff (reset)
        rx_push |-> rx_space
    ) else $error("receive byte pushed into a full FIFO");

endmodule

// ==== source/spi_master_subsystem.sv ====
// SPI master top: transmit and receive FIFOs around the clock and shift engine
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_master_subsystem (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       cpol,
    input  logic                       cpha,
    input  logic                       tx_valid,
    output logic                       tx_ready,
    input  logic [`SPI_WORD_WIDTH-1:0] tx_data,
    output logic                       rx_valid,
    input  logic                       rx_ready,
    output logic [`SPI_WORD_WIDTH-1:0] rx_data,
    input  logic                       miso,
    output spi_pkg::spi_pins_t         pins,
    output logic                       busy
);

    spi_pkg::spi_mode_t         mode_in;
    spi_pkg::spi_mode_t         mode;
    spi_pkg::spi_state_e        state;
    logic                       tx_avail;
    logic                       tx_pop;
    logic [`SPI_WORD_WIDTH-1:0] tx_byte;
    logic                       rx_space;
    logic                       rx_push;
    logic [`SPI_WORD_WIDTH-1:0] rx_byte;
    logic                       run;
    logic                       sclk;
    logic                       lead_edge;
    logic                       trail_edge;

    assign mode_in.cpol = cpol;
    assign mode_in.cpha = cpha;
    assign busy         = (state != spi_pkg::spi_idle);

    spi_byte_fifo tx_fifo (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (tx_valid),
        .in_ready  (tx_ready),
        .in_data   (tx_data),
        .out_valid (tx_avail),
        .out_ready (tx_pop),
        .out_data  (tx_byte)
    );

    spi_byte_fifo rx_fifo (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (rx_push),
        .in_ready  (rx_space),
        .in_data   (rx_byte),
        .out_valid (rx_valid),
        .out_ready (rx_ready),
        .out_data  (rx_data)
    );

    spi_clock_phase clock_phase (
        .clock      (clock),
        .reset      (reset),
        .run        (run),
        .mode       (mode),
        .sclk       (sclk),
        .lead_edge  (lead_edge),
        .trail_edge (trail_edge)
    );

    spi_shift_engine shift_engine (
        .clock      (clock),
        .reset      (reset),
        .mode_in    (mode_in),
        .tx_valid   (tx_avail),
        .tx_pop     (tx_pop),
        .tx_byte    (tx_byte),
        .rx_space   (rx_space),
        .rx_push    (rx_push),
        .rx_byte    (rx_byte),
        .run        (run),
        .mode       (mode),
        .sclk       (sclk),
        .lead_edge  (lead_edge),
        .trail_edge (trail_edge),
        .miso       (miso),
        .pins       (pins),
        .state      (state)
    );

endmodule

// ==== dv/spi_slave_model.sv ====
// Behavioral SPI slave that captures MOSI frames and replies with the last frame XOR A5
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_slave_model (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       cpol,
    input  logic                       cpha,
    input  spi_pkg::spi_pins_t         pins,
    output logic                       miso,
    output logic                       captured_valid,
    output logic [`SPI_WORD_WIDTH-1:0] captured_byte,
    output logic                       edge_fault
);

    localparam int WORD = `SPI_WORD_WIDTH;

    spi_pkg::spi_pins_t prev;
    logic [WORD-1:0]    shift_in;
    logic [WORD-1:0]    shift_out;
    logic [WORD-1:0]    last_mosi;
    int                 edges;

    // Pins looked at between system clock edges
    // An sclk edge seen here took place at the rising edge just before,
    // so the MOSI bit it samples is the level from the previous look
    always @(negedge clock) begin
        logic leading;
        logic trailing;
        leading        = (prev.sclk == cpol) && (pins.sclk != cpol);
        trailing       = (prev.sclk != cpol) && (pins.sclk == cpol);
        captured_valid <= 1'b0;
        if (reset) begin
            miso       <= 1'b0;
            edge_fault <= 1'b0;
            last_mosi  = '0;
        end else if (prev.cs_n && !pins.cs_n) begin
            // First frame replies A5 since last_mosi starts at zero
            shift_out = last_mosi ^ 8'hA5;
            edges     = 0;
            if (!cpha) begin
                miso      <= shift_out[WORD-1];
                shift_out = shift_out << 1;
            end
        end else if (!prev.cs_n) begin
            if (cpha ? trailing : leading) begin
                shift_in = {shift_in[WORD-2:0], prev.mosi};
                edges    = edges + 1;
            end
            if (cpha ? leading : trailing) begin
                miso      <= shift_out[WORD-1];
                shift_out = shift_out << 1;
            end
            if (pins.cs_n) begin
                // One sample per bit in every low period
                if (edges != WORD) begin
                    edge_fault <= 1'b1;
                end
                captured_valid <= 1'b1;
                captured_byte  <= shift_in;
                last_mosi      = shift_in;
            end
        end
        prev <= pins;
    end

endmodule

// ==== dv/spi_master_tb.sv ====
// SPI master testbench over four clock modes, back-pressure and a random receive drain
`timescale 1ns/1ps
`include "spi_settings.svh"

module spi_master_tb;

    localparam int WORD    = `SPI_WORD_WIDTH;
    localparam int TIMEOUT = 4000;

    logic               clock;
    logic               reset;
    logic               cpol;
    logic               cpha;
    logic               tx_valid;
    logic               tx_ready;
    logic [WORD-1:0]    tx_data;
    logic               rx_valid;
    logic               rx_ready;
    logic [WORD-1:0]    rx_data;
    logic               miso;
    logic               busy;
    spi_pkg::spi_pins_t pins;
    logic               captured_valid;
    logic [WORD-1:0]    captured_byte;
    logic               edge_fault;

    logic [WORD-1:0]    sent_q[$];
    logic [WORD-1:0]    expect_q[$];
    logic [255:0]       ready_pattern;
    logic [7:0]         pattern_index;
    int                 drain_mode;
    int                 rx_count;
    int                 captured_count;

    spi_master_subsystem dut (.*);

    spi_slave_model slave (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    // Reply to frame n is byte n-1 XOR A5, and A5 for the first frame
    function automatic logic [WORD-1:0] reply_for(input int index);
        if (index == 0) begin
            return 8'hA5;
        end
        return sent_q[index-1] ^ 8'hA5;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compare_values(input string name, input logic [31:0] actual,
                                  input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                               $time, name, actual, expected));
        end
    endtask

    // Starts and ends on a falling edge
    task automatic send_byte(input logic [WORD-1:0] value);
        int waited = 0;
        while (!tx_ready) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) begin
                fail_run("Timeout waiting for tx_ready to rise");
            end
        end
        tx_valid = 1'b1;
        tx_data  = value;
        expect_q.push_back(reply_for(sent_q.size()));
        sent_q.push_back(value);
        @(negedge clock);
        tx_valid = 1'b0;
    endtask

    // Stall means the engine blocked on a full rx FIFO, else every byte back
    task automatic wait_until(input bit stall);
        int waited = 0;
        while (stall ? (tx_ready || busy) : (expect_q.size() != 0 || busy)) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT) begin
                fail_run($sformatf("Timeout waiting for the %s, engine in state %s",
                                   stall ? "stall" : "drain", dut.state.name()));
            end
        end
    endtask

    // Drain mode moves on the rising edge so the receive process sees it whole
    task automatic set_drain(input int mode);
        @(posedge clock);
        drain_mode = mode;
        @(negedge clock);
    endtask

    // Receive side picks rx_ready for the coming edge and checks what it takes
    always @(negedge clock) begin
        logic ready_next;
        case (drain_mode)
            0: ready_next = 1'b0;
            1: ready_next = 1'b1;
            default: ready_next = ready_pattern[pattern_index];
        endcase
        pattern_index = pattern_index + 1'b1;
        if (!reset && ready_next && rx_valid) begin
            if (expect_q.size() == 0) begin
                fail_run("Receive byte arrived with nothing expected");
            end else begin
                compare_values("rx_data", rx_data, expect_q.pop_front());
                rx_count++;
            end
        end
        rx_ready = ready_next;
    end

    // Each low period of cs_n carries the next sent byte with eight samples
    always @(posedge clock) begin
        if (captured_valid === 1'b1) begin
            if (captured_count >= sent_q.size()) begin
                fail_run("Slave saw a frame with no byte sent for it");
            end else begin
                compare_values("slave mosi byte", captured_byte, sent_q[captured_count]);
                compare_values("slave edge_fault", edge_fault, 0);
                captured_count++;
            end
        end
    end

    initial begin
        int i;
        int mode;
        void'($urandom(91));
        for (i = 0; i < 8; i++) begin
            ready_pattern[i*32 +: 32] = $urandom;
        end
        pattern_index  = '0;
        drain_mode     = 1;
        rx_count       = 0;
        captured_count = 0;
        reset          = 1'b1;
        cpol           = 1'b0;
        cpha           = 1'b0;
        tx_valid       = 1'b0;
        tx_data        = '0;
        rx_ready       = 1'b0;
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        compare_values("tx_ready", tx_ready, 1);
        compare_values("rx_valid", rx_valid, 0);
        compare_values("pins.cs_n", pins.cs_n, 1);
        compare_values("pins.sclk", pins.sclk, 0);
        compare_values("busy", busy, 0);

        // Single bytes in every mode with the idle clock level between frames
        for (mode = 0; mode < 4; mode++) begin
            cpol = mode[1];
            cpha = mode[0];
            @(negedge clock);
            for (i = 0; i < 4; i++) begin
                compare_values("pins.sclk", pins.sclk, cpol);
                send_byte(WORD'($urandom));
                wait_until(1'b0);
                compare_values("pins.cs_n", pins.cs_n, 1);
            end
            compare_values("pins.sclk", pins.sclk, cpol);
        end

        // Receive side held off until both FIFOs fill
        set_drain(0);
        for (i = 0; i < 2 * `SPI_FIFO_DEPTH; i++) begin
            send_byte(WORD'($urandom));
        end
        wait_until(1'b1);
        compare_values("tx_ready", tx_ready, 0);
        compare_values("rx_valid", rx_valid, 1);
        compare_values("pins.cs_n", pins.cs_n, 1);
        // Only as many frames as the receive FIFO holds may run
        compare_values("frames run while held", captured_count,
                       sent_q.size() - `SPI_FIFO_DEPTH);
        set_drain(1);
        for (i = 0; i < 2; i++) begin
            send_byte(WORD'($urandom));
        end
        wait_until(1'b0);

        // Bursts against a randomly toggling rx_ready
        set_drain(2);
        for (i = 0; i < 12; i++) begin
            send_byte(WORD'($urandom));
        end
        wait_until(1'b0);

        if (rx_count == sent_q.size() && captured_count == sent_q.size()) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            fail_run($sformatf("Run ended with %0d bytes sent, %0d received, %0d frames seen",
                               sent_q.size(), rx_count, captured_count));
        end
    end

endmodule

// ==== filelist.f ====
+incdir+source
source/spi_pkg.sv
source/spi_byte_fifo.sv
source/spi_clock_phase.sv
source/spi_shift_engine.sv
source/spi_master_subsystem.sv
dv/spi_slave_model.sv
dv/spi_master_tb.sv
